// ==== duckPkg.sv ====
package duckPkg;

	localparam int FrameCount = 20;
	localparam int SpriteHeight = 8;
	localparam int SpriteDepth = 2048;
	localparam int SpriteWords = 1344;
	localparam int PaletteDepth = 16;

	localparam int ScreenHActive = 64;
	localparam int ScreenHTotal = 80;
	localparam int ScreenVActive = 48;
	localparam int ScreenVTotal = 52;
	localparam int ScreenHSyncStart = 68;
	localparam int ScreenHSyncLen = 6;
	localparam int ScreenVSyncStart = 49;
	localparam int ScreenVSyncLen = 2;

	typedef logic [3:0] colorIndex_t;
	typedef logic [4:0] frameId_t;
	typedef logic [10:0] spriteAddr_t;

	typedef struct packed {
		logic [3:0] red;
		logic [3:0] green;
		logic [3:0] blue;
	} rgb_t;

	typedef enum logic [1:0] {
		FlyRight,
		FlyLeft,
		Falling
	} duckDir_t;

	typedef struct packed {
		duckDir_t dir;
		logic red;
	} duckCmd_t;

	typedef struct packed {
		logic [6:0] posX; // Top-left corner
		logic [5:0] posY;
		frameId_t frame;
	} duckState_t;

	typedef struct packed {
		logic [6:0] hCount;
		logic [5:0] vCount;
		logic active;
	} scanPos_t;

	typedef struct packed {
		logic en;
		logic toPalette;
		spriteAddr_t addr;
		logic [11:0] data; // Sprite loads use the low nibble
	} memLoad_t;

	typedef struct packed {
		rgb_t rgb;
		logic active;
		logic hSync;
		logic vSync;
	} pixelOut_t;

	localparam rgb_t SkyColor = 12'h59F;
	localparam colorIndex_t TransparentIndex = 4'd0;

	// Per colour: right 0-3, left 4-7, falling 8-9; red is black plus 10
	localparam logic [3:0] FrameWidthTable [FrameCount] = '{
		4'd8, 4'd8, 4'd9, 4'd9, 4'd8, 4'd8, 4'd9, 4'd9, 4'd8, 4'd8,
		4'd8, 4'd8, 4'd9, 4'd9, 4'd8, 4'd8, 4'd9, 4'd9, 4'd8, 4'd8
	};

	// Frames packed back to back, row-major
	localparam spriteAddr_t FrameBaseTable [FrameCount] = '{
		11'd0, 11'd64, 11'd128, 11'd200, 11'd272,
		11'd336, 11'd400, 11'd472, 11'd544, 11'd608,
		11'd672, 11'd736, 11'd800, 11'd872, 11'd944,
		11'd1008, 11'd1072, 11'd1144, 11'd1216, 11'd1280
	};

	function automatic frameId_t frameClamp(input frameId_t frame);
		return (frame < FrameCount) ? frame : '0; // Unknown frames show frame 0
	endfunction

	function automatic logic [3:0] frameWidth(input frameId_t frame);
		return FrameWidthTable[frameClamp(frame)];
	endfunction

	function automatic spriteAddr_t frameBase(input frameId_t frame);
		return FrameBaseTable[frameClamp(frame)];
	endfunction

endpackage

// ==== syncMem.sv ====
module syncMem #(
	parameter type entryT = logic [7:0],
	parameter int Depth = 16
) (
	input logic clock,
	input logic we,
	input logic [$clog2(Depth)-1:0] wAddr,
	input entryT wData,
	input logic [$clog2(Depth)-1:0] rAddr,
	output entryT rData
);

	entryT mem [Depth];

	always_ff @(posedge clock) begin
		if (we) begin
			mem[wAddr] <= wData;
		end
	end

	// Read port registered every cycle
	always_ff @(posedge clock) begin
		rData <= mem[rAddr];
	end

endmodule

// ==== vgaTiming.sv ====
module vgaTiming import duckPkg::*; #(
	parameter int HActive = 64,
	parameter int HTotal = 80,
	parameter int VActive = 48,
	parameter int VTotal = 52,
	parameter int HSyncStart = 68,
	parameter int HSyncLen = 6,
	parameter int VSyncStart = 49,
	parameter int VSyncLen = 2
) (
	input logic clock,
	input logic arstN,
	output scanPos_t scanPos,
	output logic hSync,
	output logic vSync,
	output logic frameStart
);

	logic [6:0] hCount;
	logic [5:0] vCount;
	logic lineEnd;
	logic frameEnd;

	assign lineEnd = (hCount == 7'(HTotal - 1));
	assign frameEnd = (vCount == 6'(VTotal - 1));

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hCount <= '0;
			vCount <= '0;
		end else if (lineEnd) begin
			hCount <= '0;
			vCount <= frameEnd ? '0 : vCount + 6'd1; // Next line or back to top
		end else begin
			hCount <= hCount + 7'd1;
		end
	end

	assign scanPos = '{
		hCount: hCount,
		vCount: vCount,
		active: (hCount < HActive) && (vCount < VActive)
	};

	// Syncs are active low inside their windows
	assign hSync = !((hCount >= HSyncStart) && (hCount < HSyncStart + HSyncLen));
	assign vSync = !((vCount >= VSyncStart) && (vCount < VSyncStart + VSyncLen));

	assign frameStart = (hCount == '0) && (vCount == '0);

endmodule

// ==== duckAnimator.sv ====
module duckAnimator import duckPkg::*; #(
	parameter int HActive = 64,
	parameter int VActive = 48,
	parameter int AnimDiv = 2
) (
	input logic clock,
	input logic arstN,
	input logic frameStart,
	input duckCmd_t cmd,
	output duckState_t duck
);

	localparam int DivWidth = $clog2(AnimDiv + 1);

	duckCmd_t prevCmd;
	logic [1:0] step;
	logic [DivWidth-1:0] divCount;
	logic cmdChanged;
	logic divWrap;
	logic [1:0] stepNext;
	frameId_t groupBase;
	frameId_t frameNext;
	logic [6:0] posXNext;
	logic [5:0] posYNext;

	assign cmdChanged = (cmd != prevCmd);
	assign divWrap = (divCount == DivWidth'(AnimDiv - 1));

	always_comb begin
		if (cmdChanged) begin
			stepNext = '0; // New command restarts the cycle
		end else if (divWrap) begin
			if (cmd.dir == Falling) begin
				stepNext = {1'b0, ~step[0]}; // Two falling frames
			end else begin
				stepNext = step + 2'd1;
			end
		end else begin
			stepNext = step;
		end
	end

	always_comb begin
		case (cmd.dir)
			FlyLeft: groupBase = 5'd4;
			Falling: groupBase = 5'd8;
			default: groupBase = 5'd0;
		endcase
		frameNext = groupBase + frameId_t'(stepNext) + (cmd.red ? 5'd10 : 5'd0);
	end

	always_comb begin
		posXNext = duck.posX;
		posYNext = duck.posY;
		case (cmd.dir)
			FlyRight: posXNext = (duck.posX == 7'(HActive - 1)) ? '0 : duck.posX + 7'd1;
			FlyLeft: posXNext = (duck.posX == '0) ? 7'(HActive - 1) : duck.posX - 7'd1;
			Falling: posYNext = (duck.posY == 6'(VActive - 1)) ? '0 : duck.posY + 6'd1;
			default: posXNext = duck.posX;
		endcase
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			prevCmd <= '{dir: FlyRight, red: 1'b0};
			step <= '0;
			divCount <= '0;
			duck <= '{posX: '0, posY: '0, frame: '0};
		end else if (frameStart) begin
			prevCmd <= cmd;
			step <= stepNext;
			if (cmdChanged || divWrap) begin
				divCount <= '0;
			end else begin
				divCount <= divCount + DivWidth'(1);
			end
			duck <= '{posX: posXNext, posY: posYNext, frame: frameNext};
		end
	end

endmodule

// ==== duckSpriteBank.sv ====
module duckSpriteBank import duckPkg::*; (
	input logic clock,
	input frameId_t frame,
	input logic [2:0] row,
	input logic [3:0] col,
	input memLoad_t memLoad,
	output colorIndex_t index
);

	spriteAddr_t base;
	spriteAddr_t rowOffset;
	spriteAddr_t readAddr;
	logic spriteWe;

	// Row-major layout within each frame
	always_comb begin
		base = frameBase(frame);
		rowOffset = spriteAddr_t'(row) * spriteAddr_t'(frameWidth(frame));
		readAddr = base + rowOffset + spriteAddr_t'(col);
	end

	assign spriteWe = memLoad.en && !memLoad.toPalette;

	syncMem #(
		.entryT(colorIndex_t),
		.Depth(SpriteDepth)
	) spriteMem_i (
		.clock(clock),
		.we(spriteWe),
		.wAddr(memLoad.addr),
		.wData(memLoad.data[3:0]), // Index sits in the low nibble
		.rAddr(readAddr),
		.rData(index)
	);

endmodule

// ==== duckCompositor.sv ====
module duckCompositor import duckPkg::*; (
	input logic clock,
	input logic arstN,
	input scanPos_t scanPos,
	input logic hSync,
	input logic vSync,
	input duckState_t duck,
	input memLoad_t memLoad,
	output pixelOut_t pixel
);

	typedef struct packed {
		logic inBox;
		logic active;
		logic hSync;
		logic vSync;
	} stageFlags_t;

	localparam stageFlags_t FlagsIdle = '{inBox: 1'b0, active: 1'b0, hSync: 1'b1, vSync: 1'b1};

	logic [7:0] boxRight;
	logic [6:0] boxBottom;
	logic inBox0;
	logic [6:0] relX;
	logic [5:0] relY;
	colorIndex_t bankIndex;
	colorIndex_t index2;
	rgb_t paletteColor;
	rgb_t pixelRgb;
	stageFlags_t stage1;
	stageFlags_t stage2;
	logic paletteWe;

	// Stage 0: box test without wrap, edge columns fall in blanking
	always_comb begin
		boxRight = {1'b0, duck.posX} + 8'(frameWidth(duck.frame));
		boxBottom = {1'b0, duck.posY} + 7'(SpriteHeight);
		inBox0 = (scanPos.hCount >= duck.posX) && ({1'b0, scanPos.hCount} < boxRight) &&
			(scanPos.vCount >= duck.posY) && ({1'b0, scanPos.vCount} < boxBottom);
		relX = scanPos.hCount - duck.posX;
		relY = scanPos.vCount - duck.posY;
	end

	duckSpriteBank duckSpriteBank_i (
		.clock(clock),
		.frame(duck.frame),
		.row(relY[2:0]),
		.col(relX[3:0]),
		.memLoad(memLoad),
		.index(bankIndex)
	);

	assign paletteWe = memLoad.en && memLoad.toPalette;

	syncMem #(
		.entryT(rgb_t),
		.Depth(PaletteDepth)
	) paletteMem_i (
		.clock(clock),
		.we(paletteWe),
		.wAddr(memLoad.addr[3:0]),
		.wData(rgb_t'(memLoad.data)),
		.rAddr(bankIndex), // Index straight from the bank register
		.rData(paletteColor)
	);

	always_ff @(posedge clock) begin
		index2 <= bankIndex; // Kept beside the palette read
	end

	always_comb begin
		if (!stage2.active) begin
			pixelRgb = '0;
		end else if (!stage2.inBox || index2 == TransparentIndex) begin
			pixelRgb = SkyColor;
		end else begin
			pixelRgb = paletteColor;
		end
	end

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			stage1 <= FlagsIdle;
			stage2 <= FlagsIdle;
			pixel <= '{rgb: '0, active: 1'b0, hSync: 1'b1, vSync: 1'b1};
		end else begin
			stage1 <= '{inBox: inBox0, active: scanPos.active, hSync: hSync, vSync: vSync};
			stage2 <= stage1;
			pixel <= '{
				rgb: pixelRgb,
				active: stage2.active,
				hSync: stage2.hSync,
				vSync: stage2.vSync
			};
		end
	end

endmodule

// ==== duckRenderTop.sv ====
module duckRenderTop import duckPkg::*; #(
	parameter int HActive = ScreenHActive,
	parameter int HTotal = ScreenHTotal,
	parameter int VActive = ScreenVActive,
	parameter int VTotal = ScreenVTotal,
	parameter int HSyncStart = ScreenHSyncStart,
	parameter int HSyncLen = ScreenHSyncLen,
	parameter int VSyncStart = ScreenVSyncStart,
	parameter int VSyncLen = ScreenVSyncLen,
	parameter int AnimDiv = 2 // Video frames per animation step
) (
	input logic clock,
	input logic arstN,
	input duckCmd_t cmd,
	input memLoad_t memLoad,
	output pixelOut_t pixel
);

	scanPos_t scanPos;
	logic hSync;
	logic vSync;
	logic frameStart;
	duckState_t duck;

	vgaTiming #(
		.HActive(HActive),
		.HTotal(HTotal),
		.VActive(VActive),
		.VTotal(VTotal),
		.HSyncStart(HSyncStart),
		.HSyncLen(HSyncLen),
		.VSyncStart(VSyncStart),
		.VSyncLen(VSyncLen)
	) vgaTiming_i (
		.clock(clock),
		.arstN(arstN),
		.scanPos(scanPos),
		.hSync(hSync),
		.vSync(vSync),
		.frameStart(frameStart)
	);

	duckAnimator #(
		.HActive(HActive),
		.VActive(VActive),
		.AnimDiv(AnimDiv)
	) duckAnimator_i (
		.clock(clock),
		.arstN(arstN),
		.frameStart(frameStart),
		.cmd(cmd),
		.duck(duck)
	);

	duckCompositor duckCompositor_i (
		.clock(clock),
		.arstN(arstN),
		.scanPos(scanPos),
		.hSync(hSync),
		.vSync(vSync),
		.duck(duck),
		.memLoad(memLoad),
		.pixel(pixel)
	);

endmodule

// ==== duckRenderTop_sva.sv ====
module duckRenderTop_sva import duckPkg::*; (
	input logic clock,
	input logic arstN,
	input logic hSync,
	input logic vSync,
	input pixelOut_t pixel
);

	blankIsBlack: assert property (@(posedge clock) disable iff (!arstN)
		!pixel.active |-> pixel.rgb == '0)
		else $error("Inactive pixel carries colour %h", pixel.rgb);

	// Pipeline still drains reset values
	quietAfterReset: assert property (@(posedge clock)
		$rose(arstN) |-> !pixel.active [*3])
		else $error("Pixel output became active within three cycles of reset release");

	hSyncDelay: assert property (@(posedge clock) disable iff (!arstN)
		pixel.hSync == $past(hSync, 3))
		else $error("hSync output does not follow its input by three cycles");

	vSyncDelay: assert property (@(posedge clock) disable iff (!arstN)
		pixel.vSync == $past(vSync, 3))
		else $error("vSync output does not follow its input by three cycles");

endmodule

bind duckCompositor duckRenderTop_sva duckRenderTop_sva_i (
	.clock(clock),
	.arstN(arstN),
	.hSync(hSync),
	.vSync(vSync),
	.pixel(pixel)
);

// ==== duckRenderTop_tb.sv ====
module duckRenderTop_tb import duckPkg::*; ();

	localparam int HActive = 64;
	localparam int HTotal = 80;
	localparam int VActive = 48;
	localparam int VTotal = 52;
	localparam int HSyncStart = 68;
	localparam int HSyncLen = 6;
	localparam int VSyncStart = 49;
	localparam int VSyncLen = 2;
	localparam int AnimDiv = 2;
	localparam int SpriteRows = 8;
	localparam int SpriteWordCount = 1344;
	localparam int PaletteWordCount = 16;
	localparam rgb_t SkyRgb = 12'h59F;
	localparam int ClockPeriod = 8;
	localparam int ResetCycles = 16;
	localparam int FrameCycles = HTotal * VTotal;
	localparam int LoadCycles = SpriteWordCount + PaletteWordCount;
	localparam int LastFrameStart = 15; // Run ends at the fifteenth frame start
	localparam int WatchdogCycles = ResetCycles + LoadCycles + 14 * FrameCycles + 2 * FrameCycles;

	logic clock = 1'b0;
	logic arstN;
	duckCmd_t cmd;
	memLoad_t memLoad;
	pixelOut_t pixel;

	logic [31:0] lfsrState;
	logic [3:0] spriteModel [SpriteWordCount];
	rgb_t paletteModel [PaletteWordCount];
	int widthOf [20];
	int baseOf [20];
	duckState_t modelDuck;
	duckCmd_t modelPrevCmd;
	int modelStep;
	int modelDiv;
	int frameNum;
	int checkCount;
	logic loadsDone;

	duckRenderTop #(
		.HActive(HActive),
		.HTotal(HTotal),
		.VActive(VActive),
		.VTotal(VTotal),
		.HSyncStart(HSyncStart),
		.HSyncLen(HSyncLen),
		.VSyncStart(VSyncStart),
		.VSyncLen(VSyncLen),
		.AnimDiv(AnimDiv)
	) duckRenderTop_i (
		.clock(clock),
		.arstN(arstN),
		.cmd(cmd),
		.memLoad(memLoad),
		.pixel(pixel)
	);

	always #(ClockPeriod / 2) clock = ~clock;

	// Galois LFSR, one step per bit taken
	function automatic logic [11:0] takeBits(input int count);
		logic [11:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[10:0], lfsrState[0]};
			lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		end
		return value;
	endfunction

	function automatic pixelOut_t refPixel(input int h, input int v, input duckState_t d);
		pixelOut_t p;
		int w;
		logic [3:0] idx;
		p.active = (h < HActive) && (v < VActive);
		p.hSync = !((h >= HSyncStart) && (h < HSyncStart + HSyncLen));
		p.vSync = !((v >= VSyncStart) && (v < VSyncStart + VSyncLen));
		w = widthOf[d.frame];
		if (!p.active) begin
			p.rgb = '0;
		end else if (h >= d.posX && h < d.posX + w && v >= d.posY && v < d.posY + SpriteRows) begin
			idx = spriteModel[baseOf[d.frame] + (v - d.posY) * w + (h - d.posX)];
			p.rgb = (idx == 4'd0) ? SkyRgb : paletteModel[idx]; // Index 0 lets the sky through
		end else begin
			p.rgb = SkyRgb;
		end
		return p;
	endfunction

	// Animator model, run once per frame start
	task automatic stepAnimator(input duckCmd_t c);
		int group;
		if (c != modelPrevCmd) begin
			modelStep = 0;
			modelDiv = 0;
		end else if (modelDiv == AnimDiv - 1) begin
			modelStep = (c.dir == Falling) ? (modelStep + 1) % 2 : (modelStep + 1) % 4;
			modelDiv = 0;
		end else begin
			modelDiv++;
		end
		modelPrevCmd = c;
		group = (c.dir == FlyLeft) ? 4 : ((c.dir == Falling) ? 8 : 0);
		modelDuck.frame = frameId_t'(group + modelStep + (c.red ? 10 : 0));
		case (c.dir)
			FlyRight: modelDuck.posX = 7'((modelDuck.posX + 1) % HActive);
			FlyLeft: modelDuck.posX = 7'((modelDuck.posX + HActive - 1) % HActive);
			default: modelDuck.posY = 6'((modelDuck.posY + 1) % VActive);
		endcase
	endtask

	task automatic checkValue(input string name, input logic [11:0] actual,
		input logic [11:0] expected);
		if (actual !== expected) begin
			$display("Mismatch at time %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("STATUS: FAIL");
			$fatal(1, "Pixel output differs from the reference model");
		end
	endtask

	// Reference pipeline, three cycles deep like the DUT
	initial begin : compareProc
		pixelOut_t expQ [$];
		logic chkQ [$];
		pixelOut_t want;
		int hPos;
		int vPos;
		hPos = 0;
		vPos = 0;
		@(posedge arstN);
		forever begin
			expQ.push_back(refPixel(hPos, vPos, modelDuck));
			chkQ.push_back(loadsDone);
			if (expQ.size() > 3) begin
				want = expQ.pop_front();
				if (chkQ.pop_front()) begin
					checkValue("pixel.rgb", 12'(pixel.rgb), 12'(want.rgb));
					checkValue("pixel.active", 12'(pixel.active), 12'(want.active));
					checkValue("pixel.hSync", 12'(pixel.hSync), 12'(want.hSync));
					checkValue("pixel.vSync", 12'(pixel.vSync), 12'(want.vSync));
					checkCount++;
				end
			end
			if (hPos == 0 && vPos == 0) begin
				stepAnimator(cmd); // Update lands after the first pixel of the frame
				frameNum++;
			end
			if (hPos == HTotal - 1) begin
				hPos = 0;
				vPos = (vPos == VTotal - 1) ? 0 : vPos + 1;
			end else begin
				hPos++;
			end
			@(negedge clock);
		end
	end

	initial begin : watchdog
		#(WatchdogCycles * ClockPeriod);
		$display("Timeout: the run did not finish within the expected number of frames");
		$display("STATUS: FAIL");
		$fatal(1, "Watchdog expired");
	end

	initial begin : stimulus
		int total;
		logic [3:0] spriteBits;
		logic [11:0] paletteBits;
		arstN = 1'b0;
		cmd = '{dir: FlyLeft, red: 1'b1}; // Differs from the reset command
		memLoad = '0;
		loadsDone = 1'b0;
		lfsrState = 32'h9995b7ff;
		frameNum = 0;
		checkCount = 0;
		modelDuck = '{posX: '0, posY: '0, frame: '0};
		modelPrevCmd = '{dir: FlyRight, red: 1'b0};
		modelStep = 0;
		modelDiv = 0;
		total = 0;
		for (int f = 0; f < 20; f++) begin
			widthOf[f] = ((f % 10) inside {2, 3, 6, 7}) ? 9 : 8;
			baseOf[f] = total;
			total += widthOf[f] * SpriteRows;
		end
		repeat (ResetCycles) @(negedge clock);
		arstN = 1'b1;
		for (int i = 0; i < SpriteWordCount; i++) begin
			@(negedge clock);
			spriteBits = takeBits(4);
			spriteModel[i] = spriteBits;
			memLoad = '{en: 1'b1, toPalette: 1'b0, addr: spriteAddr_t'(i), data: {8'h00, spriteBits}};
		end
		for (int i = 0; i < PaletteWordCount; i++) begin
			@(negedge clock);
			paletteBits = takeBits(12);
			paletteModel[i] = paletteBits;
			memLoad = '{en: 1'b1, toPalette: 1'b1, addr: spriteAddr_t'(i), data: paletteBits};
		end
		@(negedge clock);
		memLoad = '0;
		@(posedge clock);
		loadsDone = 1'b1;
		wait (frameNum == 2);
		@(negedge clock);
		cmd = '{dir: FlyRight, red: 1'b0}; // Duck sits at the right edge, wraps next
		wait (frameNum == 11);
		@(negedge clock);
		cmd = '{dir: Falling, red: 1'b1};
		wait (frameNum == LastFrameStart);
		repeat (4) @(negedge clock);
		if (checkCount >= 13 * FrameCycles) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			$display("Too few pixels were compared: %0d", checkCount);
			$display("STATUS: FAIL");
			$fatal(1, "Incomplete run");
		end
	end

endmodule

// ==== duckRenderTop.f ====
duckPkg.sv
syncMem.sv
vgaTiming.sv
duckAnimator.sv
duckSpriteBank.sv
duckCompositor.sv
duckRenderTop.sv
duckRenderTop_sva.sv
duckRenderTop_tb.sv
